/* sim.f */
+incdir+rtl
rtl/dma_pkg.sv
rtl/dma_req_if.sv
rtl/dma_spill_register.sv
rtl/dma_region_splitter.sv
rtl/dma_group_distributor.sv
rtl/dma_frontend.sv
tests/tb_dma_frontend.sv

/* tests/tb_dma_frontend.sv */
/*
 * Testbench for the DMA front end: random bursts against a reference
 * expansion into per-group pieces, with done pulses and busy checks
 */

`timescale 1ns/1ps

`include "dma_defines.svh"

module tb_dma_frontend;
  import dma_pkg::*;

  localparam int NumGroups = `DMA_NUM_GROUPS;
  localparam int Window    = `DMA_GROUP_WINDOW;
  localparam int LenWidth  = `DMA_LEN_WIDTH;
  localparam int WaitLimit = 20000;
  localparam logic [31:0] LfsrTaps = 32'h8020_0003;

  logic                     clk;
  logic                     reset;
  dma_req_t                 req;
  logic                     req_valid;
  logic                     req_ready;
  dma_req_t [NumGroups-1:0] group_req;
  logic [NumGroups-1:0]     group_valid;
  logic [NumGroups-1:0]     group_ready;
  logic [NumGroups-1:0]     group_done;
  logic                     busy;

  dma_req_t    exp_q [NumGroups][$];
  int          exp_cycle [NumGroups][$];
  int          pending_done [NumGroups];
  int          done_wait [NumGroups];
  int          errors;
  int          cycle_cnt;
  longint      tx_bytes;
  longint      rx_bytes;
  logic        random_ready;
  logic [31:0] stim_lfsr;
  logic [31:0] ready_lfsr;
  logic [31:0] done_lfsr;

  dma_frontend i_dut (
    .clk_i            (clk        ),
    .reset_i          (reset      ),
    .dma_req_i        (req        ),
    .dma_req_valid_i  (req_valid  ),
    .dma_req_ready_o  (req_ready  ),
    .group_req_o      (group_req  ),
    .group_req_valid_o(group_valid),
    .group_req_ready_i(group_ready),
    .group_done_i     (group_done ),
    .busy_o           (busy       )
  );

  always #2 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(inout logic [31:0] state, input int nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      state = state[0] ? ((state >> 1) ^ LfsrTaps) : (state >> 1);
      val   = {val[30:0], state[0]};
    end
    return val;
  endfunction

  // Reference: cut at every group window, owner from the window index
  function automatic void expand_burst(input dma_req_t b, input int acc_cycle);
    dma_req_t    piece;
    logic [31:0] src;
    logic [31:0] dst;
    int          remaining;
    int          room;
    int          g;
    src       = b.src_addr;
    dst       = b.dst_addr;
    remaining = b.num_bytes;
    while (remaining > 0) begin
      room            = Window - int'((dst - `DMA_TCDM_BASE) % Window);
      piece.src_addr  = src;
      piece.dst_addr  = dst;
      piece.num_bytes = LenWidth'((remaining < room) ? remaining : room);
      g               = int'(((dst - `DMA_TCDM_BASE) / Window) % NumGroups);
      exp_q[g].push_back(piece);
      exp_cycle[g].push_back(acc_cycle);
      src       = src + piece.num_bytes;
      dst       = dst + piece.num_bytes;
      remaining = remaining - piece.num_bytes;
    end
  endfunction

  function automatic bit queues_empty();
    bit empty;
    empty = 1'b1;
    for (int g = 0; g < NumGroups; g++) begin
      if (exp_q[g].size() != 0) empty = 1'b0;
    end
    return empty;
  endfunction

  // Output handshakes against the expected queues
  always @(posedge clk) begin : compare_pieces
    dma_req_t expected;
    int       acc;
    if (!reset) begin
      for (int g = 0; g < NumGroups; g++) begin
        if (group_valid[g] && group_ready[g]) begin
          rx_bytes = rx_bytes + group_req[g].num_bytes;
          pending_done[g]++;
          if (exp_q[g].size() == 0) begin
            errors++;
            $display("Unexpected piece on group %0d, dst %h", g, group_req[g].dst_addr);
          end else begin
            expected = exp_q[g].pop_front();
            acc      = exp_cycle[g].pop_front();
            if (group_req[g].src_addr !== expected.src_addr) begin
              errors++;
              $display("Mismatch group_req_o[%0d].src_addr: expected %h, got %h",
                       g, expected.src_addr, group_req[g].src_addr);
            end
            if (group_req[g].dst_addr !== expected.dst_addr) begin
              errors++;
              $display("Mismatch group_req_o[%0d].dst_addr: expected %h, got %h",
                       g, expected.dst_addr, group_req[g].dst_addr);
            end
            if (group_req[g].num_bytes !== expected.num_bytes) begin
              errors++;
              $display("Mismatch group_req_o[%0d].num_bytes: expected %h, got %h",
                       g, expected.num_bytes, group_req[g].num_bytes);
            end
            // Visible 3 cycles after acceptance, so taken one edge later at best
            if (cycle_cnt - acc < 4) begin
              errors++;
              $display("Piece on group %0d was taken %0d cycles after its burst, too early",
                       g, cycle_cnt - acc);
            end
          end
        end
      end
    end
  end

  // Done pulses a few cycles after each accepted piece
  always @(negedge clk) begin : drive_done
    int total;
    total = 0;
    for (int g = 0; g < NumGroups; g++) total += pending_done[g];
    if (!reset && total > 0 && !busy) begin
      errors++;
      $display("Mismatch busy_o: expected 1, got %h while %0d pieces wait for done",
               busy, total);
    end
    for (int g = 0; g < NumGroups; g++) begin
      group_done[g] = 1'b0;
      if (!reset && pending_done[g] > 0) begin
        if (done_wait[g] == 0) begin
          group_done[g] = 1'b1;
          pending_done[g]--;
          done_wait[g] = int'(take_bits(done_lfsr, 2));
        end else begin
          done_wait[g]--;
        end
      end
    end
  end

  always @(negedge clk) begin
    group_ready = random_ready ? NumGroups'(take_bits(ready_lfsr, NumGroups)) : '1;
  end

  task automatic send_burst(input dma_req_t b);
    int waited;
    waited = 0;
    @(negedge clk);
    req       = b;
    req_valid = 1'b1;
    while (!req_ready && waited < WaitLimit) begin // Ready comes from flops only
      @(negedge clk);
      waited++;
    end
    if (!req_ready) begin
      errors++;
      $display("Timeout: burst to %h was never accepted", b.dst_addr);
    end else begin
      expand_burst(b, cycle_cnt);
      tx_bytes = tx_bytes + b.num_bytes;
    end
    @(posedge clk);
  endtask

  // Waits for all pieces and done pulses, then busy must be low
  task automatic wait_drained();
    int waited;
    waited = 0;
    @(negedge clk);
    req_valid = 1'b0;
    while ((!queues_empty() || busy) && waited < WaitLimit) begin
      @(negedge clk);
      waited++;
    end
    if (!queues_empty() || busy) begin
      errors++;
      $display("Timeout: front end did not drain, busy_o still %b", busy);
    end
    for (int g = 0; g < NumGroups; g++) begin
      if (pending_done[g] != 0) begin
        errors++;
        $display("busy_o fell while group %0d still had pieces without done", g);
      end
    end
  endtask

  initial begin : stimulus
    dma_req_t b;
    int       gap;
    clk          = 1'b0;
    reset        = 1'b1;
    req          = '0;
    req_valid    = 1'b0;
    group_ready  = '1;
    group_done   = '0;
    random_ready = 1'b0;
    errors       = 0;
    cycle_cnt    = 0;
    tx_bytes     = 0;
    rx_bytes     = 0;
    stim_lfsr    = 32'd2;
    ready_lfsr   = 32'd2;
    done_lfsr    = 32'd2;
    for (int g = 0; g < NumGroups; g++) begin
      pending_done[g] = 0;
      done_wait[g]    = 0;
    end
    repeat (8) @(negedge clk);
    reset = 1'b0;

    @(negedge clk);
    if (group_valid !== '0) begin
      errors++;
      $display("Mismatch group_req_valid_o after reset: expected 0, got %h", group_valid);
    end
    if (busy !== 1'b0) begin
      errors++;
      $display("Mismatch busy_o after reset: expected 0, got %h", busy);
    end
    if (req_ready !== 1'b1) begin
      errors++;
      $display("Mismatch dma_req_ready_o after reset: expected 1, got %h", req_ready);
    end

    // Inside one group window
    send_burst('{src_addr: 32'h1000_0000, dst_addr: `DMA_TCDM_BASE + 32'h48, num_bytes: 16'd32});
    wait_drained();

    // Spans several interleave windows
    send_burst('{src_addr: 32'h2000_0010, dst_addr: `DMA_TCDM_BASE + 32'h1f0, num_bytes: 16'd700});
    wait_drained();

    @(posedge clk);
    random_ready = 1'b1;
    for (int i = 0; i < 40; i++) begin
      b.src_addr  = take_bits(stim_lfsr, 32);
      b.dst_addr  = `DMA_TCDM_BASE + take_bits(stim_lfsr, 12);
      b.num_bytes = LenWidth'(take_bits(stim_lfsr, 9));
      send_burst(b);
      gap = int'(take_bits(stim_lfsr, 2));
      repeat (gap) begin
        @(negedge clk);
        req_valid = 1'b0;
      end
    end
    wait_drained();
    @(posedge clk);
    random_ready = 1'b0;

    // Empty burst gives no piece at all
    send_burst('{src_addr: 32'h3000_0000, dst_addr: `DMA_TCDM_BASE + 32'h80, num_bytes: 16'd0});
    wait_drained();

    if (rx_bytes != tx_bytes) begin
      errors++;
      $display("Mismatch total num_bytes: expected %h, got %h", tx_bytes, rx_bytes);
    end

    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* rtl/dma_frontend.sv */
/*
 * DMA front end: input cut, region splitter, group distributor and
 * one register slice per group output
 */

`timescale 1ns/1ps

`include "dma_defines.svh"

module dma_frontend (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  // Incoming burst
  input  dma_pkg::dma_req_t                          dma_req_i,
  input  logic                                       dma_req_valid_i,
  output logic                                       dma_req_ready_o,
  // Pieces towards the groups
  output dma_pkg::dma_req_t [`DMA_NUM_GROUPS-1:0]    group_req_o,
  output logic              [`DMA_NUM_GROUPS-1:0]    group_req_valid_o,
  input  logic              [`DMA_NUM_GROUPS-1:0]    group_req_ready_i,
  // Completion and status
  input  logic              [`DMA_NUM_GROUPS-1:0]    group_done_i,
  output logic                                       busy_o
);

  localparam int unsigned NumGroups = `DMA_NUM_GROUPS;

  dma_req_if req_in_if ();
  dma_req_if req_cut_if ();
  dma_req_if req_split_if ();
  dma_req_if req_group_if [NumGroups] ();
  dma_req_if req_group_q_if [NumGroups] ();

  logic                 cut_occupied;
  logic                 split_busy;
  logic                 dist_busy;
  logic [NumGroups-1:0] group_occupied;

  assign req_in_if.req   = dma_req_i;
  assign req_in_if.valid = dma_req_valid_i;
  assign dma_req_ready_o = req_in_if.ready;

  dma_spill_register i_req_cut (
    .clk_i     (clk_i       ),
    .reset_i   (reset_i     ),
    .in_req    (req_in_if   ),
    .out_req   (req_cut_if  ),
    .occupied_o(cut_occupied)
  );

  dma_region_splitter i_region_splitter (
    .clk_i  (clk_i       ),
    .reset_i(reset_i     ),
    .in_req (req_cut_if  ),
    .out_req(req_split_if),
    .busy_o (split_busy  )
  );

  dma_group_distributor i_group_distributor (
    .clk_i       (clk_i       ),
    .reset_i     (reset_i     ),
    .in_req      (req_split_if),
    .group_req   (req_group_if),
    .group_done_i(group_done_i),
    .busy_o      (dist_busy   )
  );

  for (genvar g = 0; g < NumGroups; g++) begin : gen_group_cut
    dma_spill_register i_group_cut (
      .clk_i     (clk_i            ),
      .reset_i   (reset_i          ),
      .in_req    (req_group_if[g]  ),
      .out_req   (req_group_q_if[g]),
      .occupied_o(group_occupied[g])
    );

    assign group_req_o[g]          = req_group_q_if[g].req;
    assign group_req_valid_o[g]    = req_group_q_if[g].valid;
    assign req_group_q_if[g].ready = group_req_ready_i[g];
  end

  // Outstanding pieces are covered by the distributor
  assign busy_o = cut_occupied || split_busy || dist_busy || (|group_occupied);

endmodule

/* rtl/dma_group_distributor.sv */
/*
 * Group distributor: cuts chunks at group-window boundaries, steers each
 * piece to its owning group and counts pieces not yet reported done
 */

`timescale 1ns/1ps

`include "dma_defines.svh"

module dma_group_distributor (
  input  logic                        clk_i,
  input  logic                        reset_i,
  dma_req_if.sink                     in_req,
  dma_req_if.source                   group_req [`DMA_NUM_GROUPS],
  input  logic [`DMA_NUM_GROUPS-1:0]  group_done_i,
  output logic                        busy_o
);
  import dma_pkg::*;

  localparam int unsigned AddrWidth = `DMA_ADDR_WIDTH;
  localparam int unsigned LenWidth  = `DMA_LEN_WIDTH;
  localparam int unsigned NumGroups = `DMA_NUM_GROUPS;
  localparam int unsigned CntWidth  = 16;

  dma_req_t             cur_q;
  logic                 active_q;
  logic                 in_hs, piece_hs;
  dma_addr_u            dst_rel;
  group_idx_t           sel;
  logic [LenWidth-1:0]  to_boundary;
  logic [LenWidth-1:0]  piece_len;
  logic                 last_piece;
  logic [NumGroups-1:0] group_ready;
  logic [CntWidth-1:0]  outstanding_q;
  logic [CntWidth-1:0]  done_cnt;

  assign in_req.ready = !active_q;
  assign in_hs        = in_req.valid && !active_q;

  // Owning group and distance to its window end
  assign dst_rel.addr = cur_q.dst_addr - `DMA_TCDM_BASE;
  assign sel          = dst_rel.fields.group;
  assign to_boundary  = LenWidth'(`DMA_GROUP_WINDOW) - LenWidth'(dst_rel.fields.offset);

  always_comb begin
    if (cur_q.num_bytes <= to_boundary) begin
      piece_len  = cur_q.num_bytes;
      last_piece = 1'b1;
    end else begin
      piece_len  = to_boundary;
      last_piece = 1'b0;
    end
  end

  for (genvar g = 0; g < NumGroups; g++) begin : gen_group_out
    assign group_req[g].req = '{
      src_addr:  cur_q.src_addr,
      dst_addr:  cur_q.dst_addr,
      num_bytes: piece_len
    };
    assign group_req[g].valid = active_q && (sel == group_idx_t'(g));
    assign group_ready[g]     = group_req[g].ready;
  end

  // Waits on the selected group only, keeps per-group order
  assign piece_hs = active_q && group_ready[sel];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q <= 1'b0;
    end else if (in_hs) begin
      active_q <= (in_req.req.num_bytes != '0);
    end else if (piece_hs && last_piece) begin
      active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_hs) begin
      cur_q <= in_req.req;
    end else if (piece_hs) begin
      cur_q.src_addr  <= cur_q.src_addr + AddrWidth'(piece_len);
      cur_q.dst_addr  <= cur_q.dst_addr + AddrWidth'(piece_len);
      cur_q.num_bytes <= cur_q.num_bytes - piece_len;
    end
  end

  // Every done bit counts, several may arrive together
  always_comb begin
    done_cnt = '0;
    for (int unsigned g = 0; g < NumGroups; g++) begin
      done_cnt = done_cnt + CntWidth'(group_done_i[g]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + CntWidth'(piece_hs) - done_cnt;
    end
  end

  assign busy_o = active_q || (outstanding_q != '0);

endmodule

/* rtl/dma_region_splitter.sv */
/*
 * Region splitter: cuts a burst into chunks that never cross
 * an interleave window, the span of all groups together
 */

`timescale 1ns/1ps

`include "dma_defines.svh"

module dma_region_splitter (
  input  logic      clk_i,
  input  logic      reset_i,
  dma_req_if.sink   in_req,
  dma_req_if.source out_req,
  output logic      busy_o
);
  import dma_pkg::*;

  localparam int unsigned AddrWidth   = `DMA_ADDR_WIDTH;
  localparam int unsigned LenWidth    = `DMA_LEN_WIDTH;
  localparam int unsigned WindowBytes = `DMA_NUM_GROUPS * `DMA_GROUP_WINDOW;
  localparam int unsigned WindowBits  = $clog2(WindowBytes);

  dma_req_t             cur_q;
  logic                 active_q;
  logic                 in_hs, out_hs;
  logic [AddrWidth-1:0] dst_rel;
  logic [LenWidth-1:0]  to_boundary;
  logic [LenWidth-1:0]  chunk_len;
  logic                 last_chunk;

  // New burst only once the previous one is fully split
  assign in_req.ready = !active_q;
  assign in_hs        = in_req.valid && !active_q;
  assign out_hs       = active_q && out_req.ready;

  assign dst_rel     = cur_q.dst_addr - `DMA_TCDM_BASE;
  assign to_boundary = LenWidth'(WindowBytes) - LenWidth'(dst_rel[WindowBits-1:0]);

  always_comb begin
    if (cur_q.num_bytes <= to_boundary) begin
      chunk_len  = cur_q.num_bytes; // Burst ends inside this window
      last_chunk = 1'b1;
    end else begin
      chunk_len  = to_boundary;
      last_chunk = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q <= 1'b0;
    end else if (in_hs) begin
      active_q <= (in_req.req.num_bytes != '0); // Empty bursts are dropped here
    end else if (out_hs && last_chunk) begin
      active_q <= 1'b0;
    end
  end

  // Remaining part of the burst
  always_ff @(posedge clk_i) begin
    if (in_hs) begin
      cur_q <= in_req.req;
    end else if (out_hs) begin
      cur_q.src_addr  <= cur_q.src_addr + AddrWidth'(chunk_len);
      cur_q.dst_addr  <= cur_q.dst_addr + AddrWidth'(chunk_len);
      cur_q.num_bytes <= cur_q.num_bytes - chunk_len;
    end
  end

  assign out_req.valid = active_q;
  assign out_req.req   = '{
    src_addr:  cur_q.src_addr,
    dst_addr:  cur_q.dst_addr,
    num_bytes: chunk_len
  };

  assign busy_o = active_q;

endmodule

/* rtl/dma_spill_register.sv */
/*
 * Two-entry register slice; ready comes from flops only
 */

`timescale 1ns/1ps

module dma_spill_register (
  input  logic      clk_i,
  input  logic      reset_i,
  dma_req_if.sink   in_req,
  dma_req_if.source out_req,
  output logic      occupied_o
);
  import dma_pkg::*;

  dma_req_t a_data_q, b_data_q;
  logic     a_full_q, b_full_q;
  logic     has_space;
  logic     a_fill, a_drain;
  logic     b_fill, b_drain;

  assign has_space = !a_full_q || !b_full_q;
  assign in_req.ready = has_space;

  assign a_fill  = in_req.valid && has_space;
  assign a_drain = a_full_q && !b_full_q; // A empties into output or B
  assign b_fill  = a_drain && !out_req.ready;
  assign b_drain = b_full_q && out_req.ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= in_req.req;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // B always holds the older entry
  assign out_req.valid = a_full_q || b_full_q;
  assign out_req.req   = b_full_q ? b_data_q : a_data_q;

  assign occupied_o = a_full_q || b_full_q;

endmodule

/* rtl/dma_req_if.sv */
/*
 * Request channel between front end stages, valid/ready handshake
 */

`timescale 1ns/1ps

interface dma_req_if;
  import dma_pkg::*;

  dma_req_t req;
  logic     valid;
  logic     ready;

  // Producer side
  modport source (
    output req,
    output valid,
    input  ready
  );

  // Consumer side
  modport sink (
    input  req,
    input  valid,
    output ready
  );

endinterface

/* rtl/dma_pkg.sv */
/*
 * DMA front end types: burst request and TCDM destination address views
 */

`include "dma_defines.svh"

package dma_pkg;

  // Burst request as it travels through the front end
  typedef struct packed {
    logic [`DMA_ADDR_WIDTH-1:0] src_addr;
    logic [`DMA_ADDR_WIDTH-1:0] dst_addr;
    logic [`DMA_LEN_WIDTH-1:0]  num_bytes;
  } dma_req_t;

  typedef logic [$clog2(`DMA_NUM_GROUPS)-1:0] group_idx_t;

  // TCDM-relative address split into interleaving fields
  typedef struct packed {
    logic [`DMA_ADDR_WIDTH-$clog2(`DMA_NUM_GROUPS)-$clog2(`DMA_GROUP_WINDOW)-1:0] row;
    group_idx_t                                                             group;
    logic [$clog2(`DMA_GROUP_WINDOW)-1:0]                                   offset;
  } dma_addr_fields_t;

  // Same word seen flat or by field
  typedef union packed {
    logic [`DMA_ADDR_WIDTH-1:0] addr;
    dma_addr_fields_t           fields;
  } dma_addr_u;

endpackage

/* rtl/dma_defines.svh */
/*
 * DMA front end constants: widths, group layout and TCDM base
 */

`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Address and byte-count widths
`define DMA_ADDR_WIDTH 32
`define DMA_LEN_WIDTH 16

// Number of groups, power of two
`define DMA_NUM_GROUPS 4

// Bytes owned by one group in each interleave window, power of two
`define DMA_GROUP_WINDOW 64

// Start of the TCDM region; all destinations lie behind it
`define DMA_TCDM_BASE 32'h0000_0000

`endif
